// ==== tb.f ====
hdl/vgaPkg.sv
hdl/prizePkg.sv
hdl/regularPrize.sv
hdl/specialPrize.sv
hdl/objectMux.sv
hdl/prizeDisplay.sv
testbench/prizeDisplayTb.sv

// ==== Bender.yml ====
package:
  name: prize_display

sources:
  # packages first, the drawers import both
  - hdl/vgaPkg.sv
  - hdl/prizePkg.sv
  # drawers and mux
  - hdl/regularPrize.sv
  - hdl/specialPrize.sv
  - hdl/objectMux.sv
  # top level
  - hdl/prizeDisplay.sv
  # testbench
  - target: test
    files:
      - testbench/prizeDisplayTb.sv

// ==== testbench/prizeDisplayTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module prizeDisplayTb
	import vgaPkg::*;
	import prizePkg::*;
();

	localparam int prizeSize = 24;	// DUT defaults
	localparam int tileOffset = 20;
	localparam int halfSize = prizeSize / 2;
	localparam int waitLimit = 100;	// cycles
	localparam rgb8 squareColors [4] = '{8'h3B, 8'h4B, 8'h5B, 8'h6B};

	typedef struct packed {
		rgb8 rgb;
		logic draw;
		pixelCoord offX;
		pixelCoord offY;
	} pixelResult;

	// inputs as the drawers sample them
	typedef struct packed {
		pixelCoord px;
		pixelCoord py;
		pixelCoord regTX;
		pixelCoord regTY;
		prizeKind regK;
		colorIndex regC;
		pixelCoord specTX;
		pixelCoord specTY;
		prizeKind specK;
	} sceneSnap;

	logic clk = 1'b0;
	logic resetN;
	pixelCoord pixelX;
	pixelCoord pixelY;
	pixelCoord regTileX;
	pixelCoord regTileY;
	prizeKind regKind;
	colorIndex regColor;
	pixelCoord specTileX;
	pixelCoord specTileY;
	prizeKind specKind;
	rgb8 bgColor;
	rgb8 rgbOut;
	logic drawing;
	pixelCoord offsetX;
	pixelCoord offsetY;

	logic [31:0] lfsrState = 32'h83b2;
	pixelResult wantQueue [$];	// one entry in flight
	sceneSnap prevSnap;
	logic armed = 1'b0;	// first pixel sampled with reset high

	prizeDisplay DUT (.*);

	always #2 clk = ~clk;	// 4 ns period

	// galois LFSR, x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	// expected top outputs for one pixel, bg taken one cycle later
	function automatic pixelResult expectedPixel(input sceneSnap s, input rgb8 bg);
		pixelResult r;
		int regDX;
		int regDY;
		int specDX;
		int specDY;
		int distX;
		int distY;
		logic regHit;
		logic specHit;
		regDX = int'(s.px) - int'(s.regTX) - tileOffset;
		regDY = int'(s.py) - int'(s.regTY) - tileOffset;
		specDX = int'(s.px) - int'(s.specTX) - tileOffset;
		specDY = int'(s.py) - int'(s.specTY) - tileOffset;
		distX = (specDX >= halfSize) ? specDX - halfSize : halfSize - specDX;
		distY = (specDY >= halfSize) ? specDY - halfSize : halfSize - specDY;
		regHit = (s.regK == regular) && regDX >= 0 && regDX < prizeSize
			&& regDY >= 0 && regDY < prizeSize;
		specHit = (s.specK == speedBonus || s.specK == lifeBonus || s.specK == scoreBonus)
			&& specDX >= 0 && specDX < prizeSize && specDY >= 0 && specDY < prizeSize
			&& (distX + distY) < halfSize;	// diamond inside its box
		if (specHit) begin
			case (s.specK)
				speedBonus: r.rgb = 8'hE0;
				lifeBonus:  r.rgb = 8'h1C;
				default:    r.rgb = 8'hFC;	// score bonus
			endcase
			r.draw = 1'b1;
			r.offX = pixelCoord'(specDX);
			r.offY = pixelCoord'(specDY);
		end else if (regHit) begin
			r.rgb = squareColors[s.regC];
			r.draw = 1'b1;
			r.offX = pixelCoord'(regDX);
			r.offY = pixelCoord'(regDY);
		end else begin
			r.rgb = bg;	// background, no object
			r.draw = 1'b0;
			r.offX = '0;
			r.offY = '0;
		end
		return r;
	endfunction

	function automatic sceneSnap currentSnap();
		return '{pixelX, pixelY, regTileX, regTileY, regKind, regColor,
			specTileX, specTileY, specKind};
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic checkColor(input string name, input rgb8 got, input rgb8 want);
		if (got !== want)
			failRun($sformatf("Fail %s got %h expected %h at %0t", name, got, want, $time));
	endtask

	task automatic checkCoord(input string name, input pixelCoord got, input pixelCoord want);
		if (got !== want)
			failRun($sformatf("Fail %s got %h expected %h at %0t", name, got, want, $time));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want)
			failRun($sformatf("Fail %s got %h expected %h at %0t", name, got, want, $time));
	endtask

	// outputs settle after the rising edge, compare at the falling one
	always @(negedge clk) begin
		pixelResult want;
		if (!resetN || !armed) begin
			checkColor("rgbOut", rgbOut, '0);	// reset values, no pixel through yet
			checkFlag("drawing", drawing, 1'b0);
			checkCoord("offsetX", offsetX, '0);
			checkCoord("offsetY", offsetY, '0);
			armed = resetN;
			prevSnap = currentSnap();
		end else begin
			if (wantQueue.size() > 0) begin
				want = wantQueue.pop_front();
				checkColor("rgbOut", rgbOut, want.rgb);
				checkFlag("drawing", drawing, want.draw);
				checkCoord("offsetX", offsetX, want.offX);
				checkCoord("offsetY", offsetY, want.offY);
			end
			wantQueue.push_back(expectedPixel(prevSnap, bgColor));	// mux sees bg now
			prevSnap = currentSnap();
		end
	end

	task automatic applyPixel(input int x, input int y);
		@(posedge clk);
		pixelX <= pixelCoord'(x);
		pixelY <= pixelCoord'(y);
	endtask

	task automatic setScene(input int regX, input int regY, input prizeKind rk,
		input colorIndex rc, input int specX, input int specY, input prizeKind sk,
		input rgb8 bg);
		@(posedge clk);
		regTileX <= pixelCoord'(regX);
		regTileY <= pixelCoord'(regY);
		regKind <= rk;
		regColor <= rc;
		specTileX <= pixelCoord'(specX);
		specTileY <= pixelCoord'(specY);
		specKind <= sk;
		bgColor <= bg;
	endtask

	// raster over an object box, one pixel past every edge
	task automatic scanTile(input int tx, input int ty);
		for (int y = ty + tileOffset - 1; y <= ty + tileOffset + prizeSize; y++)
			for (int x = tx + tileOffset - 1; x <= tx + tileOffset + prizeSize; x++)
				applyPixel(x, y);
	endtask

	initial begin
		int waited;
		int tx;
		int ty;
		logic [2:0] regBits;
		logic [2:0] specBits;
		resetN = 1'b0;
		pixelX = '0;
		pixelY = '0;
		regTileX = '0;
		regTileY = '0;
		regKind = none;
		regColor = '0;
		specTileX = '0;
		specTileY = '0;
		specKind = none;
		bgColor = '0;
		repeat (2) @(posedge clk);
		resetN <= 1'b1;
		waited = 0;
		while (resetN !== 1'b1 && waited < waitLimit) begin
			@(posedge clk);
			waited++;
		end
		if (resetN !== 1'b1)
			failRun("reset release never seen");

		for (int c = 0; c < 4; c++) begin	// square, each palette entry
			setScene(100, 60, regular, colorIndex'(c), 400, 300, none, 8'h25);
			scanTile(100, 60);
		end
		for (int k = 2; k <= 4; k++) begin	// diamond, each bonus kind
			setScene(300, 200, none, 0, 300, 200, prizeKind'(k), 8'h92);
			scanTile(300, 200);
		end
		setScene(300, 200, regular, 2, 300, 200, lifeBonus, 8'h49);	// box corners show the square
		scanTile(300, 200);
		setScene(200, 100, regular, 1, 210, 108, scoreBonus, 8'h6D);	// partial overlap
		scanTile(205, 104);
		setScene(200, 100, none, 3, 210, 108, regular, 8'h11);	// both gated off
		scanTile(205, 104);
		setScene(200, 100, none, 0, 210, 108, none, 8'h12);
		scanTile(205, 104);

		for (int n = 0; n < 2000; n++) begin
			if (n % 32 == 0) begin	// new scene, bonus tile close enough to overlap
				tx = int'(randomBits(9));
				ty = int'(randomBits(8));
				regBits = 3'(randomBits(3));
				specBits = 3'(randomBits(3));
				setScene(tx, ty, prizeKind'(regBits), colorIndex'(randomBits(2)),
					tx + int'(randomBits(4)), ty + int'(randomBits(4)),
					prizeKind'(specBits), 8'h00);
			end
			@(posedge clk);
			pixelX <= pixelCoord'(tx + int'(randomBits(6)));
			pixelY <= pixelCoord'(ty + int'(randomBits(6)));
			bgColor <= rgb8'(randomBits(8));	// changes every pixel
		end

		repeat (3) @(posedge clk);	// drain both register stages
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/prizeDisplay.sv ====
`timescale 1ns/10ps
`default_nettype none

module prizeDisplay
	import vgaPkg::*;
	import prizePkg::*;
#(
	parameter int prizeSize = 24,	// square side and diamond box width
	parameter int tileOffset = 20	// tile corner to object corner
) (
	input wire logic clk,
	input wire logic resetN,
	input wire pixelCoord pixelX,	// from the display controller
	input wire pixelCoord pixelY,
	input wire pixelCoord regTileX,	// regular prize tile
	input wire pixelCoord regTileY,
	input wire prizeKind regKind,
	input wire colorIndex regColor,
	input wire pixelCoord specTileX,	// bonus prize tile
	input wire pixelCoord specTileY,
	input wire prizeKind specKind,
	input wire rgb8 bgColor,	// used at the mux stage
	output rgb8 rgbOut,	// two cycles after the pixel
	output logic drawing,
	output pixelCoord offsetX,
	output pixelCoord offsetY
);

	logic regDraw;	// drawer stage outputs
	rgb8 regRgb;
	pixelCoord regOffX;
	pixelCoord regOffY;
	logic specDraw;
	rgb8 specRgb;
	pixelCoord specOffX;
	pixelCoord specOffY;

	regularPrize #(
		.prizeSize(prizeSize),
		.tileOffset(tileOffset)
	) regularPrizeInst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileX(regTileX),
		.tileY(regTileY),
		.kind(regKind),
		.colorSel(regColor),
		.drawReq(regDraw),
		.rgb(regRgb),
		.offX(regOffX),
		.offY(regOffY)
	);

	specialPrize #(
		.prizeSize(prizeSize),
		.tileOffset(tileOffset)
	) specialPrizeInst (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileX(specTileX),
		.tileY(specTileY),
		.kind(specKind),
		.drawReq(specDraw),
		.rgb(specRgb),
		.offX(specOffX),
		.offY(specOffY)
	);

	objectMux objectMuxInst (
		.clk(clk),
		.resetN(resetN),
		.regDraw(regDraw),
		.regRgb(regRgb),
		.regOffX(regOffX),
		.regOffY(regOffY),
		.specDraw(specDraw),
		.specRgb(specRgb),
		.specOffX(specOffX),
		.specOffY(specOffY),
		.bgColor(bgColor),
		.rgbOut(rgbOut),
		.drawing(drawing),
		.offsetX(offsetX),
		.offsetY(offsetY)
	);

endmodule

`default_nettype wire

// ==== hdl/objectMux.sv ====
`timescale 1ns/10ps
`default_nettype none

module objectMux
	import vgaPkg::*;
(
	input wire logic clk,
	input wire logic resetN,
	input wire logic regDraw,	// regular square, one cycle after the pixel
	input wire rgb8 regRgb,
	input wire pixelCoord regOffX,
	input wire pixelCoord regOffY,
	input wire logic specDraw,	// bonus diamond, same cycle as the regular one
	input wire rgb8 specRgb,
	input wire pixelCoord specOffX,
	input wire pixelCoord specOffY,
	input wire rgb8 bgColor,	// shown where no object draws
	output rgb8 rgbOut,
	output logic drawing,	// some object won this pixel
	output pixelCoord offsetX,	// offsets of the winning object
	output pixelCoord offsetY
);

	// bonus prizes sit on top of regular ones
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rgbOut <= '0;
			drawing <= 1'b0;
			offsetX <= '0;
			offsetY <= '0;
		end else if (specDraw) begin
			rgbOut <= specRgb;	// special wins
			drawing <= 1'b1;
			offsetX <= specOffX;
			offsetY <= specOffY;
		end else if (regDraw) begin
			rgbOut <= regRgb;
			drawing <= 1'b1;
			offsetX <= regOffX;
			offsetY <= regOffY;
		end else begin
			rgbOut <= bgColor;	// background, no offsets
			drawing <= 1'b0;
			offsetX <= '0;
			offsetY <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/specialPrize.sv ====
`timescale 1ns/10ps
`default_nettype none

module specialPrize
	import vgaPkg::*;
	import prizePkg::*;
#(
	parameter int prizeSize = 24,	// width of the diamond's box
	parameter int tileOffset = 20	// tile corner to box corner
) (
	input wire logic clk,
	input wire logic resetN,
	input wire pixelCoord pixelX,	// current scan position
	input wire pixelCoord pixelY,
	input wire pixelCoord tileX,	// top-left corner of the bonus tile
	input wire pixelCoord tileY,
	input wire prizeKind kind,
	output logic drawReq,	// pixel lies inside the diamond
	output rgb8 rgb,
	output pixelCoord offX,	// offset from the box's top-left corner
	output pixelCoord offY
);

	localparam int halfSize = prizeSize / 2;	// centre of the box, also the diamond radius

	typedef logic [$bits(pixelCoord):0] wideCoord;

	wideCoord leftX;	// box edges
	wideCoord topY;
	wideCoord relX;	// pixel relative to the box corner
	wideCoord relY;
	wideCoord distX;	// absolute distance from the centre
	wideCoord distY;
	logic insideBox;
	logic insideDiamond;
	logic isBonus;

	assign leftX = wideCoord'(tileX) + wideCoord'(tileOffset);
	assign topY = wideCoord'(tileY) + wideCoord'(tileOffset);
	assign relX = wideCoord'(pixelX) - leftX;
	assign relY = wideCoord'(pixelY) - topY;

	// coarse test on the bounding box first
	assign insideBox = (wideCoord'(pixelX) >= leftX) && (relX < wideCoord'(prizeSize))
		&& (wideCoord'(pixelY) >= topY) && (relY < wideCoord'(prizeSize));

	// |rel - half|, only meaningful inside the box
	assign distX = (relX >= wideCoord'(halfSize)) ? relX - wideCoord'(halfSize)
		: wideCoord'(halfSize) - relX;
	assign distY = (relY >= wideCoord'(halfSize)) ? relY - wideCoord'(halfSize)
		: wideCoord'(halfSize) - relY;

	// manhattan distance below the radius, box corners fall outside
	assign insideDiamond = insideBox && ((distX + distY) < wideCoord'(halfSize));

	assign isBonus = kind inside {speedBonus, lifeBonus, scoreBonus};	// regular and none never draw here

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReq <= 1'b0;
			rgb <= '0;
			offX <= '0;
			offY <= '0;
		end else if (isBonus && insideDiamond) begin
			drawReq <= 1'b1;
			rgb <= bonusColor(kind);	// colour follows the bonus kind
			offX <= relX[$bits(pixelCoord)-1:0];
			offY <= relY[$bits(pixelCoord)-1:0];
		end else begin
			drawReq <= 1'b0;
			rgb <= transparentColor;
			offX <= '0;
			offY <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/regularPrize.sv ====
`timescale 1ns/10ps
`default_nettype none

module regularPrize
	import vgaPkg::*;
	import prizePkg::*;
#(
	parameter int prizeSize = 24,	// side of the square
	parameter int tileOffset = 20	// tile corner to square corner
) (
	input wire logic clk,
	input wire logic resetN,
	input wire pixelCoord pixelX,	// current scan position
	input wire pixelCoord pixelY,
	input wire pixelCoord tileX,	// top-left corner of the prize tile
	input wire pixelCoord tileY,
	input wire prizeKind kind,
	input wire colorIndex colorSel,	// palette entry for this prize
	output logic drawReq,	// pixel lies inside the square
	output rgb8 rgb,
	output pixelCoord offX,	// offset from the square's top-left corner
	output pixelCoord offY
);

	// one extra bit keeps tile + offset from wrapping
	typedef logic [$bits(pixelCoord):0] wideCoord;

	wideCoord leftX;	// square edges
	wideCoord topY;
	wideCoord relX;	// pixel relative to the square corner
	wideCoord relY;
	logic insideSquare;

	assign leftX = wideCoord'(tileX) + wideCoord'(tileOffset);
	assign topY = wideCoord'(tileY) + wideCoord'(tileOffset);
	assign relX = wideCoord'(pixelX) - leftX;	// wraps when left of the square, guarded below
	assign relY = wideCoord'(pixelY) - topY;

	// edges at 0 and prizeSize-1 are inside
	assign insideSquare = (wideCoord'(pixelX) >= leftX) && (relX < wideCoord'(prizeSize))
		&& (wideCoord'(pixelY) >= topY) && (relY < wideCoord'(prizeSize));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReq <= 1'b0;
			rgb <= '0;
			offX <= '0;
			offY <= '0;
		end else if (kind == regular && insideSquare) begin
			drawReq <= 1'b1;
			rgb <= regularColors[colorSel];	// palette lookup
			offX <= relX[$bits(pixelCoord)-1:0];	// in-square offsets for the bitmap stage
			offY <= relY[$bits(pixelCoord)-1:0];
		end else begin
			drawReq <= 1'b0;
			rgb <= transparentColor;	// nothing drawn here
			offX <= '0;
			offY <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/prizePkg.sv ====
`default_nettype none

package prizePkg;

	import vgaPkg::*;	// rgb8 and the transparent encoding

	// prize type as supplied by the game logic
	typedef enum logic [2:0] {
		none       = 3'd0,	// empty tile
		regular    = 3'd1,	// plain prize, square drawer
		speedBonus = 3'd2,	// bonus kinds, diamond drawer
		lifeBonus  = 3'd3,
		scoreBonus = 3'd4
	} prizeKind;

	// selects one of the regular colours
	typedef logic [1:0] colorIndex;

	// regular prize palette, entry 0 first
	localparam rgb8 regularColors [4] = '{8'h3B, 8'h4B, 8'h5B, 8'h6B};

	// colour of a bonus prize, transparent for anything that is not a bonus
	function automatic rgb8 bonusColor(input prizeKind kind);
		rgb8 color;
		case (kind)
			speedBonus: color = 8'hE0;	// red
			lifeBonus:  color = 8'h1C;	// green
			scoreBonus: color = 8'hFC;	// yellow
			default:    color = transparentColor;	// none, regular or unused codes
		endcase
		return color;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/vgaPkg.sv ====
`default_nettype none

package vgaPkg;

	// visible frame
	localparam int frameWidth = 640;	// pixels per line
	localparam int frameHeight = 480;	// lines per frame

	// larger frame side sets the coordinate range
	localparam int frameMaxSide = (frameWidth > frameHeight) ? frameWidth : frameHeight;

	// one spare bit so a tile plus its offset may run past the frame edge
	localparam int coordBits = $clog2(frameMaxSide) + 1;	// 11 for 640x480

	// screen coordinate, also used for tile positions and in-object offsets
	typedef logic [coordBits-1:0] pixelCoord;

	// colour in 3-3-2 format, red in the top bits
	typedef logic [7:0] rgb8;

	// bitmap value for a pixel that is not drawn
	localparam rgb8 transparentColor = 8'hFF;

endpackage

`default_nettype wire
